//--- filelist.f
hdl/i2c_pkg.sv
hdl/i2c_clk_div.sv
hdl/i2c_bit_ctrl.sv
hdl/i2c_byte_ctrl.sv
hdl/i2c_cmd_queue.sv
hdl/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/i2c_checker.sv
verif/i2c_tb.sv

//--- verif/i2c_tb.sv
`timescale 1ns/1ns

module i2c_tb import i2c_pkg::*; ();

        localparam int CLK_DIV   = 4;
        localparam int CMD_DEPTH = 4;
        localparam int N_ROWS    = 12;
        // four quarters per bit plus the handshake cycles.
        localparam int BIT_NS    = (4 * CLK_DIV + 4) * 20;
        localparam int LIMIT_NS  = N_ROWS * 25 * BIT_NS + 200 * 20;

        logic                  CLOCK_50;
        logic                  rst_n;
        logic                  cmd_push;
        logic [I2C_ADDR_W-1:0] cmd_addr;
        logic                  cmd_rw;
        logic [I2C_DATA_W-1:0] cmd_data;
        logic                  cmd_credit;
        logic                  busy;
        logic                  done;
        logic                  nack;
        logic [I2C_DATA_W-1:0] rd_data;
        logic                  scl;
        wire                   sda;
        logic [31:0]           lfsr;
        int                    credits;
        int                    tests;
        int                    errors;
        logic                  finished;

        // columns are address, rw, data, random data flag.
        function automatic logic [16:0] table_row(input int i);
                case (i)
                0:       return {7'h50, 1'b1, 8'h00, 1'b0};
                1:       return {7'h50, 1'b0, 8'h3c, 1'b0};
                2:       return {7'h50, 1'b1, 8'h00, 1'b0};
                3:       return {7'h21, 1'b0, 8'h77, 1'b0};
                4:       return {7'h50, 1'b1, 8'h00, 1'b0};
                5:       return {7'h7f, 1'b1, 8'h00, 1'b0};
                6:       return {7'h50, 1'b0, 8'h00, 1'b1};
                7:       return {7'h50, 1'b1, 8'h00, 1'b0};
                8:       return {7'h50, 1'b0, 8'h00, 1'b1};
                9:       return {7'h50, 1'b1, 8'h00, 1'b0};
                10:      return {7'h50, 1'b0, 8'h00, 1'b1};
                default: return {7'h50, 1'b1, 8'h00, 1'b0};
                endcase
        endfunction

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        function automatic logic [7:0] rand_byte();
                logic [7:0] b;
                b = '0;
                for (int k = 0; k < 8; k++) begin
                        lfsr = lfsr_step(lfsr);
                        b    = {b[6:0], lfsr[0]};
                end
                return b;
        endfunction

        initial CLOCK_50 = 1'b0;
        always #10 CLOCK_50 = ~CLOCK_50;

        i2c_master_top #(.CLK_DIV(CLK_DIV), .CMD_DEPTH(CMD_DEPTH)) i2c_master_top_i (
                .CLOCK_50(CLOCK_50), .rst_n(rst_n), .cmd_push(cmd_push),
                .cmd_addr(cmd_addr), .cmd_rw(cmd_rw), .cmd_data(cmd_data),
                .cmd_credit(cmd_credit), .busy(busy), .done(done), .nack(nack),
                .rd_data(rd_data), .scl(scl), .sda(sda)
        );

        pullup (sda);

        i2c_slave_model i2c_slave_model_i (.scl(scl), .sda(sda));

        i2c_checker #(.CMD_DEPTH(CMD_DEPTH), .N_TESTS(N_ROWS)) i2c_checker_i (
                .CLOCK_50(CLOCK_50), .rst_n(rst_n), .cmd_push(cmd_push),
                .cmd_addr(cmd_addr), .cmd_rw(cmd_rw), .cmd_data(cmd_data),
                .cmd_credit(cmd_credit), .busy(busy), .done(done), .nack(nack),
                .rd_data(rd_data), .scl(scl), .sda(sda), .tests(tests),
                .errors(errors), .finished(finished)
        );

        initial begin : stimulus
                logic [16:0] r;
                int          i;
                rst_n    = 1'b0;
                cmd_push = 1'b0;
                cmd_addr = '0;
                cmd_rw   = 1'b0;
                cmd_data = '0;
                lfsr     = 32'hbec8;
                credits  = CMD_DEPTH;
                repeat (5) @(posedge CLOCK_50);
                #2 rst_n = 1'b1;
                repeat (4) @(posedge CLOCK_50);
                i = 0;
                // push whenever a credit is held.
                while (i < N_ROWS) begin
                        @(posedge CLOCK_50);
                        if (cmd_credit) begin
                                credits++;
                        end
                        #2 cmd_push = 1'b0;
                        if (credits > 0) begin
                                r        = table_row(i);
                                cmd_addr = r[16:10];
                                cmd_rw   = r[9];
                                cmd_data = r[0] ? rand_byte() : r[8:1];
                                cmd_push = 1'b1;
                                credits--;
                                i++;
                        end
                end
                @(posedge CLOCK_50);
                #2 cmd_push = 1'b0;
                wait (finished === 1'b1);
                $display("tests run %0d, errors %0d", tests, errors);
                if (errors == 0) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

        initial begin : watchdog
                #(LIMIT_NS);
                $display("timeout, the transactions did not all finish in %0d ns", LIMIT_NS);
                $display("TEST FAILED");
                $finish;
        end

endmodule

//--- verif/i2c_checker.sv
`timescale 1ns/1ns

module i2c_checker import i2c_pkg::*; #(
        parameter int CMD_DEPTH = 4,
        parameter int N_TESTS   = 1
) (
        input  logic                  CLOCK_50,
        input  logic                  rst_n,
        input  logic                  cmd_push,
        input  logic [I2C_ADDR_W-1:0] cmd_addr,
        input  logic                  cmd_rw,
        input  logic [I2C_DATA_W-1:0] cmd_data,
        input  logic                  cmd_credit,
        input  logic                  busy,
        input  logic                  done,
        input  logic                  nack,
        input  logic [I2C_DATA_W-1:0] rd_data,
        input  logic                  scl,
        input  logic                  sda,
        output int                    tests = 0,
        output int                    errors = 0,
        output logic                  finished = 1'b0
);

        logic [15:0] pushed [$];
        logic [15:0] cur;
        logic [17:0] bits;
        logic [7:0]  ref_mem = 8'ha5;
        logic        scl_d;
        logic        sda_d;
        logic        pend;
        logic        pend_v;
        logic        stopped;
        logic        rst_seen = 1'b0;
        int          nbits;
        int          credits;
        int          fails;

        task automatic compare_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
                if (got !== exp) begin
                        $display("Mismatch %s: got %h, expected %h", name, got, exp);
                        fails++;
                end
        endtask

        task automatic close_test(input string what);
                if (tests == N_TESTS) begin
                        compare_value("credit count", credits, CMD_DEPTH);
                end
                $display("test %0d: %s %s", tests, what, (fails == 0) ? "ok" : "bad");
                errors   = errors + fails;
                tests    = tests + 1;
                finished = (tests == N_TESTS + 1);
        endtask

        // target at 7'h50 acks and keeps the last written byte.
        task automatic score_transaction();
                if (pushed.size() == 0 || !stopped) begin
                        $display("done pulsed without a completed bus transaction");
                        fails++;
                end else begin
                        cur = pushed.pop_front();
                        if (cur[15:9] == 7'h50) begin
                                compare_value("sda bit count", nbits, 18);
                                compare_value("sda bits", bits, {cur[15:8], 1'b0,
                                              cur[8] ? ref_mem : cur[7:0], cur[8]});
                                compare_value("nack", nack, 0);
                                if (cur[8]) begin
                                        compare_value("rd_data", rd_data, ref_mem);
                                end else begin
                                        ref_mem = cur[7:0];
                                end
                        end else begin
                                compare_value("sda bit count", nbits, 9);
                                compare_value("sda bits", bits[8:0], {cur[15:8], 1'b1});
                                compare_value("nack", nack, 1);
                        end
                        stopped = 1'b0;
                end
                close_test($sformatf("addr %h rw %0d", cur[15:9], cur[8]));
        endtask

        always @(posedge CLOCK_50) begin
                fails = 0;
                if (!rst_n) begin
                        scl_d   = 1'b1;
                        sda_d   = 1'b1;
                        pend    = 1'b0;
                        stopped = 1'b0;
                        credits = CMD_DEPTH;
                end else begin
                        if (!rst_seen) begin
                                rst_seen = 1'b1;
                                compare_value("scl", scl, 1);
                                compare_value("sda", sda, 1);
                                compare_value("busy", busy, 0);
                                compare_value("done", done, 0);
                                compare_value("cmd_credit", cmd_credit, 0);
                                close_test("reset state");
                        end
                        if (cmd_push) begin
                                credits--;
                                pushed.push_back({cmd_addr, cmd_rw, cmd_data});
                        end
                        if (cmd_credit) begin
                                credits++;
                                if (credits > CMD_DEPTH) begin
                                        $display("credit returned with no command outstanding");
                                        errors++;
                                end
                        end
                        // a bit counts once scl falls, so the stop edge adds none.
                        if (scl && scl_d && sda_d && !sda) begin
                                nbits   = 0;
                                pend    = 1'b0;
                                stopped = 1'b0;
                        end else if (scl && scl_d && !sda_d && sda) begin
                                stopped = 1'b1;
                        end else if (scl && !scl_d) begin
                                pend   = 1'b1;
                                pend_v = sda;
                        end else if (!scl && scl_d && pend) begin
                                bits  = {bits[16:0], pend_v};
                                nbits = nbits + 1;
                                pend  = 1'b0;
                        end
                        scl_d = scl;
                        sda_d = sda;
                        if (done) begin
                                score_transaction();
                        end
                end
        end

endmodule

//--- verif/i2c_slave_model.sv
`timescale 1ns/1ns

module i2c_slave_model #(
        parameter logic [6:0] ADDR = 7'h50
) (
        input logic scl,
        inout wire  sda
);

        logic       pull_low = 1'b0;
        logic       selected = 1'b0;
        logic       rd_mode = 1'b0;
        logic [7:0] mem = 8'ha5;
        logic [7:0] sh;
        int         cnt = 0;
        int         nbyte = 0;

        assign sda = pull_low ? 1'b0 : 1'bz;

        // start condition.
        always @(negedge sda) begin
                if (scl === 1'b1) begin
                        cnt      = 0;
                        nbyte    = 0;
                        selected = 1'b0;
                        pull_low = 1'b0;
                end
        end

        always @(posedge scl) begin
                if (cnt < 8) begin
                        sh = {sh[6:0], sda};
                end
                cnt = cnt + 1;
        end

        // drive only while scl is low.
        always @(negedge scl) begin
                #2;
                if (cnt == 9) begin
                        cnt   = 0;
                        nbyte = nbyte + 1;
                end
                if (cnt == 8 && nbyte == 0) begin
                        selected = (sh[7:1] == ADDR);
                        rd_mode  = sh[0];
                end
                if (cnt == 8 && nbyte == 1 && selected && !rd_mode) begin
                        mem = sh;
                end
                if (!selected || nbyte > 1) begin
                        pull_low = 1'b0;
                end else if (cnt == 8) begin
                        // the master acks read data itself.
                        pull_low = !(rd_mode && nbyte == 1);
                end else begin
                        pull_low = rd_mode && nbyte == 1 && !mem[7 - cnt];
                end
        end

endmodule

//--- hdl/i2c_master_top.sv
`timescale 1ns/1ns

module i2c_master_top import i2c_pkg::*; #(
        parameter int CLK_DIV   = 125,
        parameter int CMD_DEPTH = 4
) (
        input  logic                  CLOCK_50,
        input  logic                  rst_n,
        input  logic                  cmd_push,
        input  logic [I2C_ADDR_W-1:0] cmd_addr,
        input  logic                  cmd_rw,
        input  logic [I2C_DATA_W-1:0] cmd_data,
        output logic                  cmd_credit,
        output logic                  busy,
        output logic                  done,
        output logic                  nack,
        output logic [I2C_DATA_W-1:0] rd_data,
        output logic                  scl,
        inout  wire                   sda
);

        logic                  q_valid;
        logic [I2C_ADDR_W-1:0] q_addr;
        logic                  q_rw;
        logic [I2C_DATA_W-1:0] q_data;
        logic                  q_pop;
        logic                  bit_go;
        bit_cmd_t              bit_cmd;
        logic                  bit_wr;
        logic                  bit_busy;
        logic                  bit_done;
        logic                  bit_rd;
        logic                  sda_oe_n;
        logic                  run;
        logic                  tick;

        // open drain, the pullup gives the high level.
        assign sda = sda_oe_n ? 1'bz : 1'b0;

        i2c_cmd_queue #(.CMD_DEPTH(CMD_DEPTH)) i2c_cmd_queue_i (
                .CLOCK_50(CLOCK_50), .rst_n(rst_n),
                .cmd_push(cmd_push), .cmd_addr(cmd_addr), .cmd_rw(cmd_rw),
                .cmd_data(cmd_data), .cmd_credit(cmd_credit),
                .q_valid(q_valid), .q_addr(q_addr), .q_rw(q_rw),
                .q_data(q_data), .q_pop(q_pop)
        );

        i2c_byte_ctrl i2c_byte_ctrl_i (
                .CLOCK_50(CLOCK_50), .rst_n(rst_n),
                .q_valid(q_valid), .q_addr(q_addr), .q_rw(q_rw),
                .q_data(q_data), .q_pop(q_pop),
                .bit_busy(bit_busy), .bit_done(bit_done), .bit_rd(bit_rd),
                .bit_go(bit_go), .bit_cmd(bit_cmd), .bit_wr(bit_wr),
                .busy(busy), .done(done), .nack(nack), .rd_data(rd_data)
        );

        i2c_bit_ctrl i2c_bit_ctrl_i (
                .CLOCK_50(CLOCK_50), .rst_n(rst_n), .tick(tick),
                .bit_go(bit_go), .bit_cmd(bit_cmd), .bit_wr(bit_wr),
                .sda_in(sda), .scl(scl), .sda_oe_n(sda_oe_n), .run(run),
                .bit_busy(bit_busy), .bit_done(bit_done), .bit_rd(bit_rd)
        );

        i2c_clk_div #(.CLK_DIV(CLK_DIV)) i2c_clk_div_i (
                .CLOCK_50(CLOCK_50), .rst_n(rst_n), .run(run), .tick(tick)
        );

endmodule

//--- hdl/i2c_cmd_queue.sv
`timescale 1ns/1ns

module i2c_cmd_queue import i2c_pkg::*; #(
        parameter int CMD_DEPTH = 4
) (
        input  logic                  CLOCK_50,
        input  logic                  rst_n,
        input  logic                  cmd_push,
        input  logic [I2C_ADDR_W-1:0] cmd_addr,
        input  logic                  cmd_rw,
        input  logic [I2C_DATA_W-1:0] cmd_data,
        output logic                  cmd_credit,
        output logic                  q_valid,
        output logic [I2C_ADDR_W-1:0] q_addr,
        output logic                  q_rw,
        output logic [I2C_DATA_W-1:0] q_data,
        input  logic                  q_pop
);

        localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
        localparam int CNT_W = $clog2(CMD_DEPTH + 1);
        localparam int ENT_W = I2C_ADDR_W + 1 + I2C_DATA_W;

        logic [ENT_W-1:0] mem [CMD_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
                return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
        endfunction

        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        wr_ptr     <= '0;
                        rd_ptr     <= '0;
                        count      <= '0;
                        cmd_credit <= 1'b0;
                end else begin
                        if (cmd_push) begin
                                wr_ptr <= ptr_inc(wr_ptr);
                        end
                        if (q_pop) begin
                                rd_ptr <= ptr_inc(rd_ptr);
                        end
                        if (cmd_push && !q_pop) begin
                                count <= count + 1'b1;
                        end else if (q_pop && !cmd_push) begin
                                count <= count - 1'b1;
                        end
                        // credit goes back as the entry leaves.
                        cmd_credit <= q_pop;
                end
        end

        always_ff @(posedge CLOCK_50) begin
                if (cmd_push) begin
                        mem[wr_ptr] <= {cmd_addr, cmd_rw, cmd_data};
                end
        end

        assign {q_addr, q_rw, q_data} = mem[rd_ptr];
        assign q_valid = (count != '0);

        a_push_credit: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                cmd_push |-> count != CNT_W'(CMD_DEPTH));
        a_pop_empty: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                q_pop |-> count != '0);

endmodule

//--- hdl/i2c_byte_ctrl.sv
`timescale 1ns/1ns

module i2c_byte_ctrl import i2c_pkg::*; (
        input  logic                  CLOCK_50,
        input  logic                  rst_n,
        input  logic                  q_valid,
        input  logic [I2C_ADDR_W-1:0] q_addr,
        input  logic                  q_rw,
        input  logic [I2C_DATA_W-1:0] q_data,
        output logic                  q_pop,
        input  logic                  bit_busy,
        input  logic                  bit_done,
        input  logic                  bit_rd,
        output logic                  bit_go,
        output bit_cmd_t              bit_cmd,
        output logic                  bit_wr,
        output logic                  busy,
        output logic                  done,
        output logic                  nack,
        output logic [I2C_DATA_W-1:0] rd_data
);

        localparam logic [2:0] S_IDLE  = 3'd0;
        localparam logic [2:0] S_START = 3'd1;
        localparam logic [2:0] S_ADDR  = 3'd2;
        localparam logic [2:0] S_DATA  = 3'd3;
        localparam logic [2:0] S_STOP  = 3'd4;

        logic [2:0]            state;
        logic [3:0]            cnt;
        logic [I2C_DATA_W-1:0] shreg;
        logic [I2C_DATA_W-1:0] data_r;
        logic                  rw_r;
        logic                  last_bit;
        logic                  byte_done;

        assign q_pop     = (state == S_IDLE) && q_valid;
        assign busy      = (state != S_IDLE);
        assign last_bit  = (cnt == 4'd8);
        assign byte_done = bit_done && (state == S_ADDR || state == S_DATA);

        // ninth bit of each byte is the ack slot.
        always_comb begin
                bit_cmd = BIT_WRITE;
                bit_wr  = shreg[I2C_DATA_W-1];
                case (state)
                S_START: bit_cmd = BIT_START;
                S_STOP:  bit_cmd = BIT_STOP;
                S_ADDR:  bit_cmd = last_bit ? BIT_READ : BIT_WRITE;
                S_DATA: begin
                        if (rw_r) begin
                                bit_cmd = last_bit ? BIT_WRITE : BIT_READ;
                                bit_wr  = 1'b1;
                        end else begin
                                bit_cmd = last_bit ? BIT_READ : BIT_WRITE;
                        end
                end
                default: bit_cmd = BIT_WRITE;
                endcase
        end

        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        state  <= S_IDLE;
                        cnt    <= 4'd0;
                        bit_go <= 1'b0;
                        done   <= 1'b0;
                        nack   <= 1'b0;
                end else begin
                        bit_go <= 1'b0;
                        done   <= 1'b0;
                        case (state)
                        S_IDLE: begin
                                if (q_valid) begin
                                        state  <= S_START;
                                        nack   <= 1'b0;
                                        bit_go <= 1'b1;
                                end
                        end
                        S_START: begin
                                if (bit_done) begin
                                        state  <= S_ADDR;
                                        cnt    <= 4'd0;
                                        bit_go <= 1'b1;
                                end
                        end
                        S_ADDR, S_DATA: begin
                                if (bit_done) begin
                                        bit_go <= 1'b1;
                                        cnt    <= cnt + 4'd1;
                                        if (last_bit) begin
                                                cnt <= 4'd0;
                                                if (state == S_DATA) begin
                                                        state <= S_STOP;
                                                        nack  <= !rw_r && bit_rd;
                                                end else if (bit_rd) begin
                                                        // no target, skip the data byte.
                                                        state <= S_STOP;
                                                        nack  <= 1'b1;
                                                end else begin
                                                        state <= S_DATA;
                                                end
                                        end
                                end
                        end
                        S_STOP: begin
                                if (bit_done) begin
                                        state <= S_IDLE;
                                        done  <= 1'b1;
                                end
                        end
                        default: state <= S_IDLE;
                        endcase
                end
        end

        always_ff @(posedge CLOCK_50) begin
                if (q_pop) begin
                        shreg  <= {q_addr, q_rw};
                        data_r <= q_data;
                        rw_r   <= q_rw;
                end else if (byte_done) begin
                        if (!last_bit) begin
                                shreg <= {shreg[I2C_DATA_W-2:0], bit_rd};
                        end else if (state == S_ADDR) begin
                                shreg <= data_r;
                        end else if (rw_r) begin
                                rd_data <= shreg;
                        end
                end
        end

        // the bit engine must have finished before a new bit is issued.
        a_go_idle: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                bit_go |-> !bit_busy);

endmodule

//--- hdl/i2c_bit_ctrl.sv
`timescale 1ns/1ns

module i2c_bit_ctrl import i2c_pkg::*; (
        input  logic     CLOCK_50,
        input  logic     rst_n,
        input  logic     tick,
        input  logic     bit_go,
        input  bit_cmd_t bit_cmd,
        input  logic     bit_wr,
        input  logic     sda_in,
        output logic     scl,
        output logic     sda_oe_n,
        output logic     run,
        output logic     bit_busy,
        output logic     bit_done,
        output logic     bit_rd
);

        bit_cmd_t   cmd_r;
        bit_cmd_t   c_sel;
        logic       wr_r;
        logic       w_sel;
        logic [1:0] phase;
        logic [1:0] q_sel;
        logic       scl_nxt;
        logic       sda_nxt;
        logic       start_bit;
        logic       step;

        assign run       = bit_busy;
        assign start_bit = bit_go && !bit_busy;
        assign step      = bit_busy && tick;

        // bus levels for the quarter about to begin.
        always_comb begin
                q_sel = start_bit ? 2'd0 : phase + 2'd1;
                c_sel = start_bit ? bit_cmd : cmd_r;
                w_sel = start_bit ? bit_wr : wr_r;
                case (c_sel)
                BIT_START: begin
                        scl_nxt = (q_sel != 2'd3);
                        sda_nxt = (q_sel == 2'd0);
                end
                BIT_STOP: begin
                        scl_nxt = (q_sel != 2'd0);
                        sda_nxt = q_sel[1];
                end
                BIT_WRITE: begin
                        scl_nxt = q_sel[0] ^ q_sel[1];
                        sda_nxt = w_sel;
                end
                default: begin
                        // read: sda released for the whole bit.
                        scl_nxt = q_sel[0] ^ q_sel[1];
                        sda_nxt = 1'b1;
                end
                endcase
        end

        always_ff @(posedge CLOCK_50) begin
                if (!rst_n) begin
                        bit_busy <= 1'b0;
                        bit_done <= 1'b0;
                        phase    <= 2'd0;
                        scl      <= 1'b1;
                        sda_oe_n <= 1'b1;
                end else begin
                        bit_done <= 1'b0;
                        if (start_bit) begin
                                bit_busy <= 1'b1;
                                phase    <= 2'd0;
                        end else if (step) begin
                                if (phase == 2'd3) begin
                                        bit_busy <= 1'b0;
                                        bit_done <= 1'b1;
                                end else begin
                                        phase <= phase + 2'd1;
                                end
                        end
                        if (start_bit || (step && phase != 2'd3)) begin
                                scl      <= scl_nxt;
                                sda_oe_n <= sda_nxt;
                        end
                end
        end

        always_ff @(posedge CLOCK_50) begin
                if (start_bit) begin
                        cmd_r <= bit_cmd;
                        wr_r  <= bit_wr;
                end
                // sample at the end of the third quarter, scl high.
                if (step && phase == 2'd2) begin
                        bit_rd <= sda_in;
                end
        end

        // data on the bus only moves under a high scl for start and stop.
        a_sda_stable: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
                (scl && $past(scl) && sda_in != $past(sda_in))
                |-> (cmd_r == BIT_START || cmd_r == BIT_STOP));

endmodule

//--- hdl/i2c_clk_div.sv
`timescale 1ns/1ns

module i2c_clk_div #(
        parameter int CLK_DIV = 125
) (
        input  logic CLOCK_50,
        input  logic rst_n,
        input  logic run,
        output logic tick
);

        localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

        logic [CNT_W-1:0] cnt;

        // held at zero while idle so each bit starts on a fresh quarter.
        always_ff @(posedge CLOCK_50) begin
                if (!rst_n || !run) begin
                        cnt <= '0;
                end else if (cnt == CNT_W'(CLK_DIV - 1)) begin
                        cnt <= '0;
                end else begin
                        cnt <= cnt + 1'b1;
                end
        end

        assign tick = run && (cnt == CNT_W'(CLK_DIV - 1));

endmodule

//--- hdl/i2c_pkg.sv
package i2c_pkg;

        // target address and data byte widths.
        localparam int I2C_ADDR_W = 7;
        localparam int I2C_DATA_W = 8;

        // one bus bit as issued by the byte sequencer.
        typedef enum logic [1:0] {
                BIT_START,
                BIT_STOP,
                BIT_WRITE,
                BIT_READ
        } bit_cmd_t;

endpackage
